// File: axi2obi_pkg.sv
package axi2obi_pkg;

  // bus widths, one word wide on both sides
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;
  // one strobe bit per data byte
  localparam int AXI_STRB_W = 4;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // bridge control states
  typedef enum logic [2:0] {
    // waiting for a read or a paired write
    IDLE,
    // obi request raised, waiting on grant
    OBI_REQ,
    // granted, waiting on obi rvalid
    OBI_WAIT,
    // write response held on b channel
    RESP_W,
    // read response held on r channel
    RESP_R
  } bridge_state_t;

endpackage

// File: axi2obi_ctrl.sv
`timescale 1ns/1ps

module axi2obi_ctrl import axi2obi_pkg::*; (
  input  logic s00_axi_aclk,
  input  logic s00_axi_aresetn,
  // axi valids and readies from the master
  input  logic arvalid_i,
  input  logic awvalid_i,
  input  logic wvalid_i,
  input  logic rready_i,
  input  logic bready_i,
  // window decode of the address being accepted
  input  logic in_window_i,
  // obi target handshake
  input  logic obi_gnt_i,
  input  logic obi_rvalid_i,
  // axi accept strobes
  output logic arready_o,
  output logic awready_o,
  output logic wready_o,
  // capture strobes to the request buffer
  output logic capture_rd_o,
  output logic capture_wr_o,
  // obi request control
  output logic obi_req_o,
  output logic obi_we_o,
  // response buffer load
  output logic resp_load_o,
  output logic resp_err_o,
  // axi response valids
  output logic rvalid_o,
  output logic bvalid_o
);

  bridge_state_t state_q;
  bridge_state_t state_d;
  // set when the last served transfer was a read, so a write wins the next tie
  logic prio_wr_q;
  // kind of the transfer in flight
  logic wr_q;
  logic rd_pend;
  logic wr_pend;
  logic pick_rd;
  logic pick_wr;

  // a write only counts once address and data are both there
  assign rd_pend = arvalid_i;
  assign wr_pend = awvalid_i & wvalid_i;

  // alternating priority, read first out of reset
  assign pick_rd = (state_q == IDLE) && rd_pend && (!wr_pend || !prio_wr_q);
  assign pick_wr = (state_q == IDLE) && wr_pend && !pick_rd;

  // accept cycle doubles as capture cycle
  assign arready_o    = pick_rd;
  assign awready_o    = pick_wr;
  assign wready_o     = pick_wr;
  assign capture_rd_o = pick_rd;
  assign capture_wr_o = pick_wr;

  // obi request straight from state
  assign obi_req_o = (state_q == OBI_REQ);
  assign obi_we_o  = wr_q;

  // responses held in their own states until the master takes them
  assign rvalid_o = (state_q == RESP_R);
  assign bvalid_o = (state_q == RESP_W);

  always_comb begin
    state_d     = state_q;
    resp_load_o = 1'b0;
    resp_err_o  = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (pick_rd || pick_wr) begin
          if (in_window_i) begin
            state_d = OBI_REQ;
          end else begin
            // out of window, answer next cycle with no obi traffic
            resp_load_o = 1'b1;
            resp_err_o  = 1'b1;
            if (pick_wr) begin
              state_d = RESP_W;
            end else begin
              state_d = RESP_R;
            end
          end
        end
      end
      OBI_REQ: begin
        if (obi_gnt_i) begin
          state_d = OBI_WAIT;
        end
      end
      OBI_WAIT: begin
        // rvalid comes for writes too
        if (obi_rvalid_i) begin
          resp_load_o = 1'b1;
          if (wr_q) begin
            state_d = RESP_W;
          end else begin
            state_d = RESP_R;
          end
        end
      end
      RESP_R: begin
        if (rready_i) begin
          state_d = IDLE;
        end
      end
      RESP_W: begin
        if (bready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      state_q   <= IDLE;
      prio_wr_q <= 1'b0;
      wr_q      <= 1'b0;
    end else begin
      state_q <= state_d;
      // remember what was served last
      if (pick_rd) begin
        prio_wr_q <= 1'b1;
        wr_q      <= 1'b0;
      end else if (pick_wr) begin
        prio_wr_q <= 1'b0;
        wr_q      <= 1'b1;
      end
    end
  end

  // obi request and its direction hold until the target grants
  a_obi_req_hold: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_we_o));

  // read response waits for rready
  a_rvalid_hold: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
    rvalid_o && !rready_i |=> rvalid_o);

  // write response waits for bready
  a_bvalid_hold: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
    bvalid_o && !bready_i |=> bvalid_o);

endmodule

// File: axi2obi_req_buf.sv
`timescale 1ns/1ps

module axi2obi_req_buf import axi2obi_pkg::*; #(
  parameter logic [AXI_ADDR_W-1:0] MEM_BASE  = 32'h0000_1000,
  parameter int                    MEM_WORDS = 64
) (
  input  logic                  s00_axi_aclk,
  input  logic                  s00_axi_aresetn,
  // axi request payloads
  input  logic [AXI_ADDR_W-1:0] araddr_i,
  input  logic [AXI_ADDR_W-1:0] awaddr_i,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  input  logic [AXI_STRB_W-1:0] wstrb_i,
  // capture strobes from the control FSM
  input  logic                  capture_rd_i,
  input  logic                  capture_wr_i,
  // decode result for the address being taken
  output logic                  in_window_o,
  // obi request fields
  output logic [AXI_ADDR_W-1:0] obi_addr_o,
  output logic [AXI_STRB_W-1:0] obi_be_o,
  output logic [AXI_DATA_W-1:0] obi_wdata_o
);

  // window end, one bit wider so a window at the top of the map does not wrap
  localparam logic [AXI_ADDR_W:0] WIN_END =
    {1'b0, MEM_BASE} + (AXI_ADDR_W + 1)'(4 * MEM_WORDS);

  logic [AXI_ADDR_W-1:0] dec_addr;

  // decode on the address as it is captured
  // lets an error answer the very next cycle
  assign dec_addr    = capture_wr_i ? awaddr_i : araddr_i;
  assign in_window_o = (dec_addr >= MEM_BASE) && ({1'b0, dec_addr} < WIN_END);

  // address and byte enables
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      obi_addr_o <= '0;
      obi_be_o   <= '0;
    end else if (capture_wr_i) begin
      obi_addr_o <= awaddr_i;
      obi_be_o   <= wstrb_i;
    end else if (capture_rd_i) begin
      obi_addr_o <= araddr_i;
      // reads fetch the whole word
      obi_be_o   <= '1;
    end
  end

  // write data, taken together with the write address
  always_ff @(posedge s00_axi_aclk) begin
    if (capture_wr_i) begin
      obi_wdata_o <= wdata_i;
    end
  end

endmodule

// File: axi2obi_resp_buf.sv
`timescale 1ns/1ps

module axi2obi_resp_buf import axi2obi_pkg::*; (
  input  logic                  s00_axi_aclk,
  input  logic                  s00_axi_aresetn,
  // load strobe from the control FSM
  input  logic                  resp_load_i,
  // set for an out-of-window access
  input  logic                  resp_err_i,
  // read word from the obi target
  input  logic [AXI_DATA_W-1:0] obi_rdata_i,
  // held toward the axi master
  output logic [AXI_DATA_W-1:0] rdata_o,
  output logic [1:0]            resp_o
);

  // response code, cleared to okay
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      resp_o <= RESP_OKAY;
    end else if (resp_load_i) begin
      if (resp_err_i) begin
        resp_o <= RESP_DECERR;
      end else begin
        resp_o <= RESP_OKAY;
      end
    end
  end

  // read data
  // only loads once per transfer, so it stays put under back-pressure
  always_ff @(posedge s00_axi_aclk) begin
    if (resp_load_i) begin
      if (resp_err_i) begin
        // decode error returns zero
        rdata_o <= '0;
      end else begin
        rdata_o <= obi_rdata_i;
      end
    end
  end

endmodule

// File: obi_sram.sv
`timescale 1ns/1ps

module obi_sram import axi2obi_pkg::*; #(
  parameter int MEM_WORDS = 64,
  parameter int GNT_WAIT  = 2
) (
  input  logic                  s00_axi_aclk,
  input  logic                  s00_axi_aresetn,
  // obi request
  input  logic                  req_i,
  input  logic [AXI_ADDR_W-1:0] addr_i,
  input  logic                  we_i,
  input  logic [AXI_STRB_W-1:0] be_i,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  // obi grant and response
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output logic [AXI_DATA_W-1:0] rdata_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  // wide enough to hold GNT_WAIT, at least one bit
  localparam int CNT_W = $clog2(GNT_WAIT + 2);

  logic [AXI_DATA_W-1:0] mem_q [MEM_WORDS];
  logic [CNT_W-1:0]      wait_q;
  logic [IDX_W-1:0]      idx;

  // word index from the offset, base is window aligned
  assign idx = addr_i[IDX_W+1:2];

  // grant once the stall count reaches GNT_WAIT
  assign gnt_o = req_i && (wait_q == CNT_W'(GNT_WAIT));

  // stall counter, runs only while a request waits
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      wait_q <= '0;
    end else if (req_i && !gnt_o) begin
      wait_q <= wait_q + 1'b1;
    end else begin
      wait_q <= '0;
    end
  end

  // array and response, memory starts out all zero
  always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn) begin
    if (!s00_axi_aresetn) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      // response one cycle after the grant, for reads and writes
      rvalid_o <= req_i && gnt_o;
      if (req_i && gnt_o) begin
        if (we_i) begin
          // byte lanes with enable set
          for (int b = 0; b < AXI_STRB_W; b++) begin
            if (be_i[b]) begin
              mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end else begin
          rdata_o <= mem_q[idx];
        end
      end
    end
  end

  // rvalid exactly one cycle after each granted request
  a_rvalid_after_gnt: assert property (@(posedge s00_axi_aclk) disable iff (!s00_axi_aresetn)
    rvalid_o == $past(req_i && gnt_o));

endmodule

// File: axi2obi_top.sv
`timescale 1ns/1ps

module axi2obi_top import axi2obi_pkg::*; #(
  parameter logic [AXI_ADDR_W-1:0] MEM_BASE  = 32'h0000_1000,
  parameter int                    MEM_WORDS = 64,
  parameter int                    GNT_WAIT  = 2
) (
  input  logic                  s00_axi_aclk,
  input  logic                  s00_axi_aresetn,
  // read address channel
  input  logic [AXI_ADDR_W-1:0] s00_axi_araddr,
  input  logic                  s00_axi_arvalid,
  output logic                  s00_axi_arready,
  // protection bits are taken and not used
  input  logic [2:0]            s00_axi_arprot,
  // read data channel
  output logic [AXI_DATA_W-1:0] s00_axi_rdata,
  output logic [1:0]            s00_axi_rresp,
  output logic                  s00_axi_rvalid,
  input  logic                  s00_axi_rready,
  // write address channel
  input  logic [AXI_ADDR_W-1:0] s00_axi_awaddr,
  input  logic                  s00_axi_awvalid,
  output logic                  s00_axi_awready,
  input  logic [2:0]            s00_axi_awprot,
  // write data channel
  input  logic [AXI_DATA_W-1:0] s00_axi_wdata,
  input  logic [AXI_STRB_W-1:0] s00_axi_wstrb,
  input  logic                  s00_axi_wvalid,
  output logic                  s00_axi_wready,
  // write response channel
  output logic [1:0]            s00_axi_bresp,
  output logic                  s00_axi_bvalid,
  input  logic                  s00_axi_bready
);

  // ctrl to request buffer
  logic                  capture_rd;
  logic                  capture_wr;
  logic                  in_window;
  // internal obi bus
  logic                  obi_req;
  logic                  obi_gnt;
  logic [AXI_ADDR_W-1:0] obi_addr;
  logic                  obi_we;
  logic [AXI_STRB_W-1:0] obi_be;
  logic [AXI_DATA_W-1:0] obi_wdata;
  logic                  obi_rvalid;
  logic [AXI_DATA_W-1:0] obi_rdata;
  // ctrl to response buffer
  logic                  resp_load;
  logic                  resp_err;
  logic [1:0]            resp;

  // one response register serves both channels
  assign s00_axi_rresp = resp;
  assign s00_axi_bresp = resp;

  axi2obi_ctrl i_axi2obi_ctrl (
    .s00_axi_aclk   (s00_axi_aclk),
    .s00_axi_aresetn(s00_axi_aresetn),
    .arvalid_i      (s00_axi_arvalid),
    .awvalid_i      (s00_axi_awvalid),
    .wvalid_i       (s00_axi_wvalid),
    .rready_i       (s00_axi_rready),
    .bready_i       (s00_axi_bready),
    .in_window_i    (in_window),
    .obi_gnt_i      (obi_gnt),
    .obi_rvalid_i   (obi_rvalid),
    .arready_o      (s00_axi_arready),
    .awready_o      (s00_axi_awready),
    .wready_o       (s00_axi_wready),
    .capture_rd_o   (capture_rd),
    .capture_wr_o   (capture_wr),
    .obi_req_o      (obi_req),
    .obi_we_o       (obi_we),
    .resp_load_o    (resp_load),
    .resp_err_o     (resp_err),
    .rvalid_o       (s00_axi_rvalid),
    .bvalid_o       (s00_axi_bvalid)
  );

  axi2obi_req_buf #(
    .MEM_BASE (MEM_BASE),
    .MEM_WORDS(MEM_WORDS)
  ) i_axi2obi_req_buf (
    .s00_axi_aclk   (s00_axi_aclk),
    .s00_axi_aresetn(s00_axi_aresetn),
    .araddr_i       (s00_axi_araddr),
    .awaddr_i       (s00_axi_awaddr),
    .wdata_i        (s00_axi_wdata),
    .wstrb_i        (s00_axi_wstrb),
    .capture_rd_i   (capture_rd),
    .capture_wr_i   (capture_wr),
    .in_window_o    (in_window),
    .obi_addr_o     (obi_addr),
    .obi_be_o       (obi_be),
    .obi_wdata_o    (obi_wdata)
  );

  axi2obi_resp_buf i_axi2obi_resp_buf (
    .s00_axi_aclk   (s00_axi_aclk),
    .s00_axi_aresetn(s00_axi_aresetn),
    .resp_load_i    (resp_load),
    .resp_err_i     (resp_err),
    .obi_rdata_i    (obi_rdata),
    .rdata_o        (s00_axi_rdata),
    .resp_o         (resp)
  );

  // word memory behind the obi port
  obi_sram #(
    .MEM_WORDS(MEM_WORDS),
    .GNT_WAIT (GNT_WAIT)
  ) i_obi_sram (
    .s00_axi_aclk   (s00_axi_aclk),
    .s00_axi_aresetn(s00_axi_aresetn),
    .req_i          (obi_req),
    .addr_i         (obi_addr),
    .we_i           (obi_we),
    .be_i           (obi_be),
    .wdata_i        (obi_wdata),
    .gnt_o          (obi_gnt),
    .rvalid_o       (obi_rvalid),
    .rdata_o        (obi_rdata)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 16
) (
  output logic aclk_o,
  output logic aresetn_o
);

  initial begin
    aclk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) aclk_o = ~aclk_o;
    end
  end

  // reset low for RST_CYCLES rising edges, released on a falling edge
  initial begin
    aresetn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge aclk_o);
    @(negedge aclk_o);
    aresetn_o = 1'b1;
  end

endmodule

// File: tb_axi2obi.sv
`timescale 1ns/1ps

module tb_axi2obi import axi2obi_pkg::*; ();

  localparam logic [31:0] MEM_BASE   = 32'h0000_1000;
  localparam int          MEM_WORDS  = 64;
  localparam logic [31:0] MEM_END    = MEM_BASE + 32'(4 * MEM_WORDS);
  localparam int          IDX_W      = $clog2(MEM_WORDS);
  localparam int          TIMEOUT    = 64;
  // quarter period after the falling edge, well before the rising one
  localparam int          SAMPLE_DLY = 2;
  localparam int          RAND_OPS   = 60;

  // one bus operation with its expected answer
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
  } op_t;

  logic        s00_axi_aclk;
  logic        s00_axi_aresetn;
  logic [31:0] s00_axi_araddr;
  logic        s00_axi_arvalid;
  logic        s00_axi_arready;
  logic [2:0]  s00_axi_arprot;
  logic [31:0] s00_axi_rdata;
  logic [1:0]  s00_axi_rresp;
  logic        s00_axi_rvalid;
  logic        s00_axi_rready;
  logic [31:0] s00_axi_awaddr;
  logic        s00_axi_awvalid;
  logic        s00_axi_awready;
  logic [2:0]  s00_axi_awprot;
  logic [31:0] s00_axi_wdata;
  logic [3:0]  s00_axi_wstrb;
  logic        s00_axi_wvalid;
  logic        s00_axi_wready;
  logic [1:0]  s00_axi_bresp;
  logic        s00_axi_bvalid;
  logic        s00_axi_bready;

  // reference copy of the memory
  logic [31:0] model_mem [MEM_WORDS];
  logic [31:0] rng;
  // kind served last, drives the expected arbitration order
  logic        last_was_rd;
  int          mismatch_cnt;
  int          fail_cnt;
  op_t         ops [$];

  tb_clk_gen #(.PERIOD_NS(8), .RST_CYCLES(16)) i_tb_clk_gen (
    .aclk_o   (s00_axi_aclk),
    .aresetn_o(s00_axi_aresetn)
  );

  axi2obi_top i_axi2obi_top (
    .s00_axi_aclk   (s00_axi_aclk),
    .s00_axi_aresetn(s00_axi_aresetn),
    .s00_axi_araddr (s00_axi_araddr),
    .s00_axi_arvalid(s00_axi_arvalid),
    .s00_axi_arready(s00_axi_arready),
    .s00_axi_arprot (s00_axi_arprot),
    .s00_axi_rdata  (s00_axi_rdata),
    .s00_axi_rresp  (s00_axi_rresp),
    .s00_axi_rvalid (s00_axi_rvalid),
    .s00_axi_rready (s00_axi_rready),
    .s00_axi_awaddr (s00_axi_awaddr),
    .s00_axi_awvalid(s00_axi_awvalid),
    .s00_axi_awready(s00_axi_awready),
    .s00_axi_awprot (s00_axi_awprot),
    .s00_axi_wdata  (s00_axi_wdata),
    .s00_axi_wstrb  (s00_axi_wstrb),
    .s00_axi_wvalid (s00_axi_wvalid),
    .s00_axi_wready (s00_axi_wready),
    .s00_axi_bresp  (s00_axi_bresp),
    .s00_axi_bvalid (s00_axi_bvalid),
    .s00_axi_bready (s00_axi_bready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // new bytes where the strobe is set, old bytes elsewhere
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic bit in_window(input logic [31:0] addr);
    return (addr >= MEM_BASE) && (addr < MEM_END);
  endfunction

  function automatic logic [IDX_W-1:0] word_idx(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - MEM_BASE;
    return off[IDX_W+1:2];
  endfunction

  task automatic wait_negedge();
    @(negedge s00_axi_aclk);
  endtask

  task automatic wait_settle();
    #(SAMPLE_DLY);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("ERROR at %0t: %s", $time, what);
      fail_cnt++;
    end
  endtask

  task automatic add_op(input bit wr, input logic [31:0] addr, input logic [31:0] wdata,
                        input logic [3:0] strb, input logic [31:0] exp_data,
                        input logic [1:0] exp_resp);
    op_t op;
    op.wr       = wr;
    op.addr     = addr;
    op.wdata    = wdata;
    op.strb     = strb;
    op.exp_data = exp_data;
    op.exp_resp = exp_resp;
    ops.push_back(op);
  endtask

  // called right after valids were driven, returns in the handshake cycle
  task automatic wait_accept(input bit is_wr);
    int cnt;
    cnt = 0;
    wait_settle();
    while (!(is_wr ? (s00_axi_awready && s00_axi_wready) : s00_axi_arready)
           && cnt < TIMEOUT) begin
      wait_negedge();
      wait_settle();
      cnt++;
    end
    check_true(cnt < TIMEOUT, is_wr ? "write was never accepted" : "read was never accepted");
    last_was_rd = !is_wr;
  endtask

  // waits for the response, holds ready low for hold cycles, then takes it
  task automatic collect_resp(input bit is_wr, input int hold, output logic [31:0] data,
                              output logic [1:0] resp);
    int cnt;
    cnt = 0;
    wait_settle();
    while (!(is_wr ? s00_axi_bvalid : s00_axi_rvalid) && cnt < TIMEOUT) begin
      wait_negedge();
      wait_settle();
      cnt++;
    end
    check_true(cnt < TIMEOUT, "response valid never came");
    data = s00_axi_rdata;
    resp = is_wr ? s00_axi_bresp : s00_axi_rresp;
    for (int h = 0; h < hold; h++) begin
      wait_negedge();
      // new requests knock while the response waits
      s00_axi_araddr  = MEM_BASE;
      s00_axi_arvalid = 1'b1;
      s00_axi_awaddr  = MEM_BASE;
      s00_axi_wstrb   = 4'h0;
      s00_axi_awvalid = 1'b1;
      s00_axi_wvalid  = 1'b1;
      wait_settle();
      check_true(is_wr ? s00_axi_bvalid : s00_axi_rvalid, "response valid dropped under stall");
      check_true(!s00_axi_arready && !s00_axi_awready && !s00_axi_wready,
                 "new transaction accepted while a response was pending");
      if (is_wr) begin
        check_val("s00_axi_bresp", 32'(s00_axi_bresp), 32'(resp));
      end else begin
        check_val("s00_axi_rresp", 32'(s00_axi_rresp), 32'(resp));
        check_val("s00_axi_rdata", s00_axi_rdata, data);
      end
    end
    wait_negedge();
    if (hold > 0) begin
      s00_axi_arvalid = 1'b0;
      s00_axi_awvalid = 1'b0;
      s00_axi_wvalid  = 1'b0;
    end
    s00_axi_bready = is_wr;
    s00_axi_rready = !is_wr;
    wait_settle();
    wait_negedge();
    s00_axi_bready = 1'b0;
    s00_axi_rready = 1'b0;
  endtask

  task automatic check_op(input op_t op, input logic [31:0] data, input logic [1:0] resp);
    if (op.wr) begin
      check_val("s00_axi_bresp", 32'(resp), 32'(op.exp_resp));
      if (in_window(op.addr)) begin
        model_mem[word_idx(op.addr)] = merge_bytes(model_mem[word_idx(op.addr)], op.wdata,
                                                   op.strb);
      end
    end else begin
      check_val("s00_axi_rresp", 32'(resp), 32'(op.exp_resp));
      check_val("s00_axi_rdata", data, op.exp_data);
    end
  endtask

  task automatic run_op(input op_t op, input int hold);
    logic [31:0] data;
    logic [1:0]  resp;
    wait_negedge();
    if (op.wr) begin
      s00_axi_awaddr  = op.addr;
      s00_axi_wdata   = op.wdata;
      s00_axi_wstrb   = op.strb;
      s00_axi_awvalid = 1'b1;
      s00_axi_wvalid  = 1'b1;
    end else begin
      s00_axi_araddr  = op.addr;
      s00_axi_arvalid = 1'b1;
    end
    wait_accept(op.wr);
    wait_negedge();
    s00_axi_arvalid = 1'b0;
    s00_axi_awvalid = 1'b0;
    s00_axi_wvalid  = 1'b0;
    collect_resp(op.wr, hold, data, resp);
    check_op(op, data, resp);
  endtask

  // read and write presented in the same cycle
  task automatic run_pair(input logic [31:0] rd_addr, input logic [31:0] wr_addr,
                          input logic [31:0] wdata);
    op_t         rd_op;
    op_t         wr_op;
    bit          first_wr;
    int          cnt;
    logic [31:0] data;
    logic [1:0]  resp;
    rd_op = '{1'b0, rd_addr, 32'h0, 4'h0, model_mem[word_idx(rd_addr)], RESP_OKAY};
    wr_op = '{1'b1, wr_addr, wdata, 4'hf, 32'h0, RESP_OKAY};
    wait_negedge();
    s00_axi_araddr  = rd_addr;
    s00_axi_arvalid = 1'b1;
    s00_axi_awaddr  = wr_addr;
    s00_axi_wdata   = wdata;
    s00_axi_wstrb   = 4'hf;
    s00_axi_awvalid = 1'b1;
    s00_axi_wvalid  = 1'b1;
    wait_settle();
    cnt = 0;
    while (!s00_axi_arready && !(s00_axi_awready && s00_axi_wready) && cnt < TIMEOUT) begin
      wait_negedge();
      wait_settle();
      cnt++;
    end
    check_true(cnt < TIMEOUT, "neither side of the pair was accepted");
    // the side not served last goes first
    check_true(s00_axi_arready == !last_was_rd, "pair served in the wrong order");
    first_wr    = !s00_axi_arready;
    last_was_rd = !first_wr;
    wait_negedge();
    if (first_wr) begin
      s00_axi_awvalid = 1'b0;
      s00_axi_wvalid  = 1'b0;
    end else begin
      s00_axi_arvalid = 1'b0;
    end
    collect_resp(first_wr, 0, data, resp);
    check_op(first_wr ? wr_op : rd_op, data, resp);
    // the other side has been waiting all along
    wait_accept(!first_wr);
    wait_negedge();
    s00_axi_arvalid = 1'b0;
    s00_axi_awvalid = 1'b0;
    s00_axi_wvalid  = 1'b0;
    collect_resp(!first_wr, 0, data, resp);
    check_op(first_wr ? rd_op : wr_op, data, resp);
  endtask

  initial begin
    op_t         rop;
    logic [31:0] r;
    int          hold;
    int          cnt;
    s00_axi_araddr  = '0;
    s00_axi_arvalid = 1'b0;
    s00_axi_arprot  = 3'b000;
    s00_axi_rready  = 1'b0;
    s00_axi_awaddr  = '0;
    s00_axi_awvalid = 1'b0;
    s00_axi_awprot  = 3'b000;
    s00_axi_wdata   = '0;
    s00_axi_wstrb   = '0;
    s00_axi_wvalid  = 1'b0;
    s00_axi_bready  = 1'b0;
    mismatch_cnt    = 0;
    fail_cnt        = 0;
    rng             = 32'd46;
    last_was_rd     = 1'b0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      model_mem[w] = '0;
    end

    // kind, address, write data, strobe, expected read data, expected response
    add_op(1'b1, 32'h0000_1000, 32'hdead_beef, 4'hf, 32'h0000_0000, RESP_OKAY);
    add_op(1'b0, 32'h0000_1000, 32'h0000_0000, 4'h0, 32'hdead_beef, RESP_OKAY);
    add_op(1'b1, 32'h0000_1004, 32'h1122_3344, 4'hf, 32'h0000_0000, RESP_OKAY);
    // bytes 0 and 2 only
    add_op(1'b1, 32'h0000_1004, 32'haabb_ccdd, 4'h5, 32'h0000_0000, RESP_OKAY);
    add_op(1'b0, 32'h0000_1004, 32'h0000_0000, 4'h0, 32'h11bb_33dd, RESP_OKAY);
    add_op(1'b1, 32'h0000_2000, 32'h1234_5678, 4'hf, 32'h0000_0000, RESP_DECERR);
    add_op(1'b0, 32'h0000_2000, 32'h0000_0000, 4'h0, 32'h0000_0000, RESP_DECERR);
    add_op(1'b0, 32'h0000_0ffc, 32'h0000_0000, 4'h0, 32'h0000_0000, RESP_DECERR);
    // first byte past the window, would alias word 0 if decoded wrong
    add_op(1'b1, 32'h0000_1100, 32'hffff_ffff, 4'hf, 32'h0000_0000, RESP_DECERR);
    add_op(1'b0, 32'h0000_1000, 32'h0000_0000, 4'h0, 32'hdead_beef, RESP_OKAY);
    add_op(1'b1, 32'h0000_10fc, 32'hcafe_f00d, 4'h8, 32'h0000_0000, RESP_OKAY);
    add_op(1'b0, 32'h0000_10fc, 32'h0000_0000, 4'h0, 32'hca00_0000, RESP_OKAY);

    cnt = 0;
    while (s00_axi_aresetn !== 1'b1 && cnt < 100) begin
      wait_negedge();
      cnt++;
    end
    check_true(s00_axi_aresetn === 1'b1, "reset was never released");
    wait_settle();
    check_true(!s00_axi_arready && !s00_axi_awready && !s00_axi_wready,
               "a ready is high right after reset");
    check_true(!s00_axi_rvalid && !s00_axi_bvalid, "a response valid is high right after reset");

    // read wins the first tie
    run_pair(32'h0000_1008, 32'h0000_100c, 32'h0bad_f00d);

    foreach (ops[i]) begin
      rng  = xorshift32(rng);
      hold = int'(rng[2:0]);
      run_op(ops[i], hold);
    end

    // table ended on a read, so the write goes first now
    run_pair(32'h0000_100c, 32'h0000_1008, 32'h5a5a_a5a5);

    for (int n = 0; n < RAND_OPS; n++) begin
      rng    = xorshift32(rng);
      r      = rng;
      rop.wr = r[0];
      // about one in eight lands outside the window
      if (r[3:1] == 3'd0) begin
        rop.addr = 32'h0000_2000 + {24'd0, r[13:8], 2'b00};
      end else begin
        rop.addr = MEM_BASE + {24'd0, r[13:8], 2'b00};
      end
      rop.strb  = r[19:16];
      hold      = int'(r[23:21]);
      rng       = xorshift32(rng);
      rop.wdata = rng;
      if (in_window(rop.addr)) begin
        rop.exp_data = rop.wr ? 32'h0 : model_mem[word_idx(rop.addr)];
        rop.exp_resp = RESP_OKAY;
      end else begin
        rop.exp_data = 32'h0;
        rop.exp_resp = RESP_DECERR;
      end
      run_op(rop, hold);
    end

    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: project.f
axi2obi_pkg.sv
axi2obi_ctrl.sv
axi2obi_req_buf.sv
axi2obi_resp_buf.sv
obi_sram.sv
axi2obi_top.sv
tb_clk_gen.sv
tb_axi2obi.sv

// File: Makefile
TOP := tb_axi2obi

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
